// File: common/hc_pkg.sv
// Host-channel data width localparams and the word, offset and length types.

package hc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int HC_DATA_WIDTH   = 64;
  localparam int HC_OFFSET_WIDTH = 8;
  localparam int HC_LENGTH_WIDTH = 8;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // One buffer word.
  typedef logic [HC_DATA_WIDTH-1:0] hc_data_t;

  // Word offset into a buffer.
  typedef logic [HC_OFFSET_WIDTH-1:0] hc_offset_t;

  // Words per transfer, 1 to 255; zero is taken as one.
  typedef logic [HC_LENGTH_WIDTH-1:0] hc_length_t;

endpackage : hc_pkg

// File: common/loopback_pkg.sv
// Loopback engine FIFO depth, fill level type and state machine enums.

package loopback_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // FIFO sizing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int LOOPBACK_FIFO_DEPTH  = 16;                          // Power of two.
  localparam int LOOPBACK_LEVEL_WIDTH = $clog2(LOOPBACK_FIFO_DEPTH) + 1; // Holds 0..DEPTH.

  typedef logic [LOOPBACK_LEVEL_WIDTH-1:0] fifo_level_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State machines
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic {
    RD_IDLE,
    RD_READING
  } read_state_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DRAIN,
    WR_DONE
  } write_state_t;

endpackage : loopback_pkg

// File: design/loopback_fifo.sv
// Synchronous FIFO with registered dequeue data, empty/full flags and fill level.

module loopback_fifo
  import hc_pkg::*, loopback_pkg::*;
#(
  parameter int FIFO_WIDTH = HC_DATA_WIDTH,
  parameter int FIFO_DEPTH = LOOPBACK_FIFO_DEPTH
)
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  enq_en,
  input  logic [FIFO_WIDTH-1:0] enq_data,
  input  logic                  deq_en,
  output logic [FIFO_WIDTH-1:0] deq_data,
  output logic                  empty,
  output logic                  full,
  output fifo_level_t           level
);

  localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

  logic [FIFO_WIDTH-1:0] mem [FIFO_DEPTH];

  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pointers and level
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end
    else begin
      if (enq_en) begin
        wr_ptr <= wr_ptr + 1'b1; // Wraps, depth is a power of two.
      end
      if (deq_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({enq_en, deq_en})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level; // Both or neither.
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage and read port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (enq_en) begin
      mem[wr_ptr] <= enq_data;
    end
    if (deq_en) begin
      deq_data <= mem[rd_ptr]; // Valid the cycle after the pop.
    end
  end

  assign empty = (level == '0);
  assign full  = (level == fifo_level_t'(FIFO_DEPTH));

endmodule : loopback_fifo

// File: loopback/read_streamer.sv
// Job start control, credit-checked read request generation and response capture.

module read_streamer
  import hc_pkg::*, loopback_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  hc_length_t  length,
  output logic        rd_req,
  output hc_offset_t  rd_offset,
  input  logic        rd_valid,
  input  hc_data_t    rd_data,
  input  fifo_level_t fifo_level,
  output logic        enq_en,
  output hc_data_t    enq_data,
  output logic        job_start,
  output hc_length_t  job_length
);

  read_state_t state;
  hc_length_t  len_q;
  hc_offset_t  last_offset;
  logic        last_issued;
  logic        drained;
  logic [1:0]  in_flight;                         // Requested, not yet enqueued.
  logic [LOOPBACK_LEVEL_WIDTH:0] credit_used;

  assign last_offset = len_q - 1'b1;
  assign job_length  = len_q;

  assign credit_used = {1'b0, fifo_level} + {{(LOOPBACK_LEVEL_WIDTH-1){1'b0}}, in_flight};

  assign rd_req = (state == RD_READING) && !last_issued &&
                  (credit_used < LOOPBACK_FIFO_DEPTH);

  // Job is over once every word has left the FIFO.
  assign drained = last_issued && (in_flight == 2'd0) && (fifo_level == '0);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= RD_IDLE;
      len_q       <= '0;
      rd_offset   <= '0;
      last_issued <= 1'b0;
      job_start   <= 1'b0;
    end
    else begin
      job_start <= 1'b0;
      case (state)
        RD_IDLE: begin
          if (start) begin
            len_q       <= (length == '0) ? hc_length_t'(1) : length;
            rd_offset   <= '0;
            last_issued <= 1'b0;
            job_start   <= 1'b1; // Seen by the write side next cycle.
            state       <= RD_READING;
          end
        end
        RD_READING: begin
          if (rd_req) begin
            rd_offset <= rd_offset + 1'b1;
            if (rd_offset == last_offset) begin
              last_issued <= 1'b1;
            end
          end
          if (drained) begin
            state <= RD_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      in_flight <= 2'd0;
      enq_en    <= 1'b0;
    end
    else begin
      in_flight <= in_flight + {1'b0, rd_req} - {1'b0, enq_en};
      enq_en    <= rd_valid;
    end
  end

  always_ff @(posedge clk) begin
    enq_data <= rd_data;
  end

endmodule : read_streamer

// File: loopback/write_streamer.sv
// FIFO drain under write back-pressure, write offset counter and finish flag.

module write_streamer
  import hc_pkg::*, loopback_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       job_start,
  input  hc_length_t job_length,
  input  logic       fifo_empty,
  output logic       deq_en,
  input  hc_data_t   deq_data,
  input  logic       wr_full,
  output logic       wr_en,
  output hc_offset_t wr_offset,
  output hc_data_t   wr_data,
  output logic       finish
);

  write_state_t state;
  hc_length_t   len_q;
  hc_offset_t   wr_count;
  hc_offset_t   last_offset;

  assign last_offset = len_q - 1'b1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pop and write strobes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // A write already in flight when wr_full rises is still taken.
  assign deq_en = (state == WR_DRAIN) && !fifo_empty && !wr_full;

  assign wr_data   = deq_data;   // Registered in the FIFO.
  assign wr_offset = wr_count;
  assign finish    = (state == WR_DONE);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_en <= 1'b0;
    end
    else begin
      wr_en <= deq_en; // One cycle behind the pop.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Drain FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= WR_IDLE;
      len_q    <= '0;
      wr_count <= '0;
    end
    else if (job_start) begin
      len_q    <= job_length;
      wr_count <= '0;
      state    <= WR_DRAIN;
    end
    else begin
      if (wr_en) begin
        wr_count <= wr_count + 1'b1;
      end
      case (state)
        WR_DRAIN: begin
          if (wr_en && (wr_count == last_offset)) begin
            state <= WR_DONE; // Finish shows the next cycle.
          end
        end
        WR_DONE: state <= WR_DONE; // Held until the next job.
        default: state <= WR_IDLE;
      endcase
    end
  end

endmodule : write_streamer

// File: loopback/loopback_top.sv
// Loopback engine top level joining read streamer, FIFO and write streamer.

module loopback_top
  import hc_pkg::*, loopback_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       start,
  input  hc_length_t length,
  output logic       rd_req,
  output hc_offset_t rd_offset,
  input  hc_data_t   rd_data,
  input  logic       rd_valid,
  output logic       wr_en,
  output hc_offset_t wr_offset,
  output hc_data_t   wr_data,
  input  logic       wr_full,
  output logic       finish
);

  logic        job_start;
  hc_length_t  job_length;
  fifo_level_t fifo_level;
  logic        fifo_empty;
  logic        enq_en;
  hc_data_t    enq_data;
  logic        deq_en;
  hc_data_t    deq_data;

  read_streamer u_read_streamer (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .length     (length),
    .rd_req     (rd_req),
    .rd_offset  (rd_offset),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .fifo_level (fifo_level),
    .enq_en     (enq_en),
    .enq_data   (enq_data),
    .job_start  (job_start),
    .job_length (job_length)
  );

  loopback_fifo u_loopback_fifo (
    .clk      (clk),
    .reset    (reset),
    .enq_en   (enq_en),
    .enq_data (enq_data),
    .deq_en   (deq_en),
    .deq_data (deq_data),
    .empty    (fifo_empty),
    .full     (),           // Credit check keeps it from overflowing.
    .level    (fifo_level)
  );

  write_streamer u_write_streamer (
    .clk        (clk),
    .reset      (reset),
    .job_start  (job_start),
    .job_length (job_length),
    .fifo_empty (fifo_empty),
    .deq_en     (deq_en),
    .deq_data   (deq_data),
    .wr_full    (wr_full),
    .wr_en      (wr_en),
    .wr_offset  (wr_offset),
    .wr_data    (wr_data),
    .finish     (finish)
  );

endmodule : loopback_top

// File: sim/loopback_assertions.sv
// FIFO flag and strobe protocol assertions, bound to the loopback engine top level.

module loopback_assertions
  import loopback_pkg::*;
(
  input logic                                   clk,
  input logic                                   reset,
  input logic                                   start,
  input logic                                   enq_en,
  input logic                                   fifo_full,
  input logic                                   deq_en,
  input logic [$clog2(LOOPBACK_FIFO_DEPTH)-1:0] fifo_rd_ptr,
  input logic                                   wr_en,
  input logic                                   finish
);

  // Entries held, counted from the enqueue and pop strobes alone.
  fifo_level_t shadow_level;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      shadow_level <= '0;
    end
    else begin
      shadow_level <= shadow_level + fifo_level_t'(enq_en) - fifo_level_t'(deq_en);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // FIFO flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  no_enq_when_full: assert property (@(posedge clk) disable iff (reset)
    enq_en |-> !fifo_full)
    else $error("enqueue while the FIFO is full");

  no_deq_when_empty: assert property (@(posedge clk) disable iff (reset)
    deq_en |-> (shadow_level != '0))
    else $error("pop while the FIFO is empty");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Strobes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // A pop shows as a step of the FIFO read pointer.
  back_to_back_writes_popped: assert property (@(posedge clk) disable iff (reset)
    (wr_en && $past(wr_en)) |->
      ((fifo_rd_ptr != $past(fifo_rd_ptr)) && ($past(fifo_rd_ptr) != $past(fifo_rd_ptr, 2))))
    else $error("back to back writes without a pop before each");

  // Start reaches the write side through job_start, two cycles in all.
  finish_held_until_start: assert property (@(posedge clk) disable iff (reset)
    $fell(finish) |-> $past(start, 2))
    else $error("finish fell without a start");

endmodule : loopback_assertions

bind loopback_top loopback_assertions u_loopback_assertions (
  .clk         (clk),
  .reset       (reset),
  .start       (start),
  .enq_en      (enq_en),
  .fifo_full   (u_loopback_fifo.full),
  .deq_en      (deq_en),
  .fifo_rd_ptr (u_loopback_fifo.rd_ptr),
  .wr_en       (wr_en),
  .finish      (finish)
);

// File: sim/loopback_tb.sv
// Loopback engine testbench with memory models, reference data, checker and watchdog.

module loopback_tb
  import hc_pkg::*, loopback_pkg::*;
();

  localparam int NUM_JOBS = 5;

  logic        clk;
  logic        reset;
  logic        start;
  hc_length_t  length;
  logic        rd_req;
  hc_offset_t  rd_offset;
  hc_data_t    rd_data;
  logic        rd_valid;
  logic        wr_en;
  hc_offset_t  wr_offset;
  hc_data_t    wr_data;
  logic        wr_full;
  logic        finish;

  logic [31:0] rng_state;
  int          job_len [NUM_JOBS];
  int          len_sum;
  logic        lengths_ready;
  int          job_id;
  int          cur_len;
  logic        random_full;
  logic        written [256];    // Offsets written in the current job.
  int          write_count;
  int          total_reqs;
  int          total_writes;
  logic        pending_req;      // Request waiting for its response.
  hc_offset_t  pending_offset;
  logic        finish_q;

  loopback_top dut (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .length    (length),
    .rd_req    (rd_req),
    .rd_offset (rd_offset),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid),
    .wr_en     (wr_en),
    .wr_offset (wr_offset),
    .wr_data   (wr_data),
    .wr_full   (wr_full),
    .finish    (finish)
  );

  always #2 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers and reference
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw_random(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value     = rng_state;
  endtask

  // Expected buffer word for an offset of a given job.
  function automatic hc_data_t src_word(input hc_offset_t offset, input int job);
    logic [63:0] x;
    x = 64'h9E37_79B9_7F4A_7C15 ^ {24'd0, job[23:0], 8'd0, offset};
    repeat (2) begin
      x = x ^ (x << 13);
      x = x ^ (x >> 7);
      x = x ^ (x << 17);
    end
    return x;
  endfunction

  task automatic wait_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic run_job(input int idx, input logic with_full, input logic extra_start);
    int waited;
    @(negedge clk);
    job_id      = idx;
    cur_len     = job_len[idx];
    random_full = with_full;
    write_count = 0;
    foreach (written[i]) written[i] = 1'b0;
    wait_cycle();
    start  = 1'b1;
    length = hc_length_t'(job_len[idx]);
    wait_cycle();
    start = 1'b0;
    wait_cycle();
    check_value("finish after start", 64'(finish), 64'd0);
    if (extra_start) begin
      waited = 0;
      while (!wr_en) begin
        wait_cycle();
        waited++;
        if (waited > 20 * cur_len + 100) stop_with_failure("no write seen in a running job");
      end
      start  = 1'b1;                 // Must be ignored mid-job.
      length = hc_length_t'(1);
      wait_cycle();
      start = 1'b0;
    end
    waited = 0;
    while (!finish) begin
      wait_cycle();
      waited++;
      if (waited > 20 * cur_len + 100) stop_with_failure("finish did not rise in time");
    end
    @(negedge clk);
    check_value("write count", 64'(write_count), 64'(cur_len));
    for (int i = 0; i < cur_len; i++) begin
      if (!written[i]) stop_with_failure($sformatf("offset %0d was never written", i));
    end
    repeat (3) begin
      wait_cycle();
      check_value("finish", 64'(finish), 64'd1);
      check_value("rd_req", 64'(rd_req), 64'd0);
      check_value("wr_en", 64'(wr_en), 64'd0);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Memory models and checker
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always begin : memory_models
    int          outstanding;
    logic [31:0] r;
    wait_cycle();
    rd_valid       = pending_req;    // One cycle read latency.
    rd_data        = pending_req ? src_word(pending_offset, job_id) : '0;
    pending_req    = rd_req;
    pending_offset = rd_offset;
    if (rd_req && (int'(rd_offset) >= cur_len)) stop_with_failure("read beyond the job length");
    // Words requested but not yet written, less a write now leaving.
    outstanding = total_reqs - total_writes - (wr_en ? 1 : 0);
    if (rd_req && (outstanding >= LOOPBACK_FIFO_DEPTH)) begin
      stop_with_failure("read requested with no FIFO room left");
    end
    total_reqs   += rd_req ? 1 : 0;
    total_writes += wr_en ? 1 : 0;
    if (wr_en) begin
      if (wr_full) stop_with_failure("write follows a pop made while wr_full was high");
      if (int'(wr_offset) >= cur_len) stop_with_failure("write beyond the job length");
      if (written[wr_offset]) stop_with_failure("offset written twice");
      check_value("wr_data", wr_data, src_word(wr_offset, job_id));
      written[wr_offset] = 1'b1;
      write_count++;
    end
    if (finish && !finish_q) begin
      check_value("write count at finish", 64'(write_count), 64'(cur_len));
    end
    finish_q = finish;
    if (random_full && !reset) begin
      draw_random(r);
      wr_full = (r[1:0] == 2'b00);
    end
    else begin
      wr_full = 1'b0;
    end
  end

  initial begin : watchdog
    wait (lengths_ready);
    repeat (20 * len_sum + 1000) @(posedge clk);
    stop_with_failure("watchdog expired before the last job finished");
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin : stimulus
    logic [31:0] r;
    clk            = 1'b0;
    reset          = 1'b1;
    start          = 1'b0;
    length         = '0;
    rd_data        = '0;
    rd_valid       = 1'b0;
    wr_full        = 1'b0;
    rng_state      = 32'd29;
    job_id         = 0;
    cur_len        = 0;
    random_full    = 1'b0;
    write_count    = 0;
    total_reqs     = 0;
    total_writes   = 0;
    pending_req    = 1'b0;
    pending_offset = '0;
    finish_q       = 1'b0;
    lengths_ready  = 1'b0;
    foreach (written[i]) written[i] = 1'b0;
    job_len[0] = 1;
    len_sum    = 1;
    for (int j = 1; j < NUM_JOBS; j++) begin
      draw_random(r);
      job_len[j] = (j == 3) ? int'(r % 93) + 4 : int'(r % 255) + 1; // Job 3 takes a late start.
      len_sum   += job_len[j];
    end
    lengths_ready = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (4) begin
      wait_cycle();
      check_value("rd_req", 64'(rd_req), 64'd0);
      check_value("wr_en", 64'(wr_en), 64'd0);
      check_value("finish", 64'(finish), 64'd0);
    end
    run_job(0, 1'b0, 1'b0);
    run_job(1, 1'b0, 1'b0);
    run_job(2, 1'b1, 1'b0);
    run_job(3, 1'b1, 1'b1);
    run_job(4, 1'b1, 1'b0);
    $display("All tests passed!");
    $finish;
  end

endmodule : loopback_tb

// File: loopback.f
common/hc_pkg.sv
common/loopback_pkg.sv
design/loopback_fifo.sv
loopback/read_streamer.sv
loopback/write_streamer.sv
loopback/loopback_top.sv
sim/loopback_assertions.sv
sim/loopback_tb.sv

// File: Makefile
SRCS := $(shell cat loopback.f)
BIN  := obj_dir/Vloopback_tb

.PHONY: all run clean

all: run

$(BIN): loopback.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module loopback_tb \
		-f loopback.f -o Vloopback_tb

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir
